// ==== run.sh ====
#!/bin/sh
# Build and run the CPU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module cpuTb -f vlog.f -Mdir obj_dir -o cpuSim > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/cpuSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Test failed" sim.log; then
	exit 1
fi
if ! grep -q "Test passed" sim.log; then
	echo "Simulation ended without a result"
	exit 1
fi
exit 0

// ==== sim/clockGen.sv ====
`timescale 1ns/100ps

module clockGen
(
	output logic clk,
	output logic rst
);

	// 4 ns period
	initial
	begin
		clk = 1'b0;
		forever
			#2 clk = ~clk;
	end

	// Reset for 16 cycles, released on a falling edge
	initial
	begin
		rst = 1'b1;
		repeat (16)
			@(posedge clk);
		@(negedge clk);
		rst = 1'b0;
	end

endmodule

// ==== sim/cpuTb.sv ====
`timescale 1ns/100ps

module cpuTb
	import cpuPkg::*;
();

	localparam int instrCount = 400;
	localparam int waitLimit = 100;
	localparam int codeEnd = 1018;

	logic clk;
	logic rst;
	wordT memReadData;
	wordT memAddr;
	wordT memWriteData;
	logic readMem;
	logic writeMem;

	wordT mem [0:4095];
	wordT modelMem [0:4095];
	wordT modelAc;
	wordT modelPc;
	flagsT modelSr;
	int valueErrors;
	int otherErrors;
	logic aborted;

	clockGen clock_i
	(
		.clk(clk),
		.rst(rst)
	);

	cpuTop dut_i
	(
		.clk(clk),
		.rst(rst),
		.memReadData(memReadData),
		.memAddr(memAddr),
		.memWriteData(memWriteData),
		.readMem(readMem),
		.writeMem(writeMem)
	);

	// Single-cycle memory, read is combinational
	assign memReadData = mem[memAddr[11:0]];

	always @(posedge clk)
	begin
		if (writeMem)
			mem[memAddr[11:0]] <= memWriteData;
	end

	always @(posedge clk)
	begin
		if (!rst)
		begin
			assert (!(readMem && writeMem))
			else reportProblem("Memory read and write requested in the same cycle");
		end
	end

	task automatic reportValue(input string what, input wordT got, input wordT expected);
		valueErrors++;
		$display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, expected);
	endtask

	task automatic reportProblem(input string what);
		otherErrors++;
		$display("%s, at %0t ns", what, $time);
	endtask

	function automatic logic [11:0] dataAddress();
		return 12'(2048 + ($urandom % 2048));
	endfunction

	function automatic logic [11:0] randomField();
		return 12'($urandom);
	endfunction

	// Code in 0..1023, data in 2048..4095, forward jumps only
	task automatic buildProgram();
		int i;
		int pc;
		int kind;
		logic changesAc;
		logic changesFlags;
		wordT instr;
		for (i = 0; i < 4096; i++)
			modelMem[i] = wordT'($urandom);
		pc = 0;
		while (pc < codeEnd)
		begin
			kind = int'($urandom % 12);
			changesAc = 1'b1;
			changesFlags = 1'b1;
			case (kind)
				0:
				begin
					instr = {4'h0, randomField()};
					changesFlags = 1'b0;
				end
				1:
				begin
					instr = {4'h1, dataAddress()};
					changesFlags = 1'b0;
				end
				2: instr = {4'h7, dataAddress()};
				3: instr = {4'h8, randomField()};
				4: instr = {4'h9, dataAddress()};
				5:
				begin
					instr = {4'hc, 12'(pc + 1 + int'($urandom % (codeEnd - pc)))};
					changesAc = 1'b0;
					changesFlags = 1'b0;
				end
				6: instr = {8'hf1, 3'b010, 5'($urandom)};
				7: instr = {8'hf1, 3'b011, 5'($urandom)};
				8:
				begin
					instr = {8'hf1, 3'b100, 5'($urandom)};
					changesFlags = 1'b0;
				end
				9:
				begin
					instr = {8'hf6, 8'($urandom)};
					changesAc = 1'b0;
				end
				10:
				begin
					instr = {8'hf9, 8'($urandom)};
					changesAc = 1'b0;
					changesFlags = 1'b0;
				end
				default:
				begin
					instr = {4'h2, randomField()};
					changesAc = 1'b0;
					changesFlags = 1'b0;
				end
			endcase
			modelMem[pc] = instr;
			pc++;
			if (changesAc)
			begin
				modelMem[pc] = {4'h3, dataAddress()};
				pc++;
			end
			if (changesFlags)
			begin
				modelMem[pc] = {8'hf9, 8'($urandom)};
				pc++;
			end
		end
		while (pc < 1023)
		begin
			modelMem[pc] = 16'h2000;
			pc++;
		end
		// Wrap back to the start of the code
		modelMem[1023] = 16'hc000;
		for (i = 0; i < 4096; i++)
			mem[i] <= modelMem[i];
	endtask

	task automatic updateZeroNeg();
		modelSr[3] = (modelAc == 16'h0000);
		modelSr[2] = modelAc[15];
	endtask

	// One instruction of the reference model
	task automatic stepModel(input wordT instr);
		logic [11:0] imm;
		wordT operand;
		wordT nextPc;
		logic [16:0] sum;
		logic [16:0] signedSum;
		logic taken;
		imm = instr[11:0];
		nextPc = modelPc + 16'd1;
		case (instr[15:12])
			4'h0: modelAc = {{4{imm[11]}}, imm};
			4'h1: modelAc = modelMem[imm];
			4'h3: modelMem[imm] = modelAc;
			4'h7:
			begin
				modelAc = modelAc & modelMem[imm];
				updateZeroNeg();
			end
			4'h8, 4'h9:
			begin
				operand = instr[12] ? modelMem[imm] : {{4{imm[11]}}, imm};
				sum = {1'b0, modelAc} + {1'b0, operand};
				// Signed result does not fit in 16 bits
				signedSum = {modelAc[15], modelAc} + {operand[15], operand};
				modelSr[1] = sum[16];
				modelSr[0] = (signedSum[16] != signedSum[15]);
				modelAc = sum[15:0];
				updateZeroNeg();
			end
			4'hc: nextPc = {4'h0, imm};
			4'hf:
			begin
				case (instr[11:8])
					4'h1:
					begin
						case (instr[7:5])
							3'b010:
							begin
								modelAc = 16'h0000;
								modelSr[3] = 1'b1;
								modelSr[2] = 1'b0;
							end
							3'b011:
							begin
								modelAc = ~modelAc;
								updateZeroNeg();
							end
							3'b100: modelAc = modelAc + 16'd1;
							default: ;
						endcase
					end
					4'h9:
					begin
						taken = 1'b0;
						for (int i = 0; i < 4; i++)
						begin
							if (instr[4+i] && (modelSr[i] == instr[i]))
								taken = 1'b1;
						end
						if (taken)
							nextPc = modelPc + 16'd2;
					end
					4'h6:
					begin
						for (int i = 0; i < 4; i++)
						begin
							if (instr[4+i])
								modelSr[i] = instr[i];
						end
					end
					default: ;
				endcase
			end
			default: ;
		endcase
		modelPc = nextPc;
	endtask

	// Outputs are sampled at the rising edge, before the registers move
	initial
	begin
		int waited;
		int executed;
		wordT instr;
		valueErrors = 0;
		otherErrors = 0;
		aborted = 1'b0;
		void'($urandom(32'hcdc871f4));
		buildProgram();
		modelAc = 16'h0000;
		modelPc = 16'h0000;
		modelSr = 4'b0000;

		waited = 0;
		@(posedge clk);
		while ((rst || !readMem) && waited < waitLimit)
		begin
			assert (!writeMem)
			else reportProblem("Memory write requested during reset");
			@(posedge clk);
			waited++;
		end
		if (rst || !readMem)
		begin
			reportProblem("Timed out waiting for the first fetch after reset");
			aborted = 1'b1;
		end

		executed = 0;
		while (!aborted && executed < instrCount)
		begin
			assert (readMem && !writeMem)
			else reportProblem("Fetch cycle without a memory read");
			assert (memAddr == modelPc)
			else reportValue("fetch address", memAddr, modelPc);
			instr = modelMem[modelPc[11:0]];
			@(posedge clk);
			if (instr[15:12] == 4'h3)
			begin
				assert (writeMem)
				else reportProblem("STa executed without a memory write");
				assert (memAddr == {4'h0, instr[11:0]})
				else reportValue("write address", memAddr, {4'h0, instr[11:0]});
				assert (memWriteData == modelAc)
				else reportValue("write data", memWriteData, modelAc);
			end
			else
			begin
				assert (!writeMem)
				else reportProblem("Memory write outside an STa execute cycle");
				// LDa, ANa and ADa read their operand
				if (instr[15:12] == 4'h1 || instr[15:12] == 4'h7 || instr[15:12] == 4'h9)
				begin
					assert (readMem)
					else reportProblem("Memory operand used without a memory read");
					assert (memAddr == {4'h0, instr[11:0]})
					else reportValue("read address", memAddr, {4'h0, instr[11:0]});
				end
			end
			stepModel(instr);
			executed++;
			@(posedge clk);
		end

		$display("Instructions: %0d, value errors: %0d, other errors: %0d",
			executed, valueErrors, otherErrors);
		if (valueErrors == 0 && otherErrors == 0 && executed == instrCount)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// ==== src/arithLogicUnit.sv ====
`timescale 1ns/100ps
`include "cpu_macros.svh"

module arithLogicUnit
	import cpuPkg::*;
(
	input wordT a,
	input wordT b,
	input aluOpT aluOp,
	output wordT result,
	output flagsT flags
);

	wordT addend;
	wordT sum;
	logic carry;
	logic overflow;
	logic isArith;

	// Increment shares the adder with a constant one
	assign addend = (aluOp == aluInc) ? wordT'(1) : b;
	assign {carry, sum} = {1'b0, a} + {1'b0, addend};

	// Same operand signs but result sign differs
	assign overflow = (a[`CPU_WORD_W-1] == addend[`CPU_WORD_W-1]) &&
		(sum[`CPU_WORD_W-1] != a[`CPU_WORD_W-1]);

	assign isArith = (aluOp == aluAdd) || (aluOp == aluInc);

	always_comb
	begin
		case (aluOp)
			aluAdd: result = sum;
			aluInc: result = sum;
			aluAnd: result = a & b;
			aluNot: result = ~a;
			default: result = sum;
		endcase
	end

	assign flags[3] = ~|result;
	assign flags[2] = result[`CPU_WORD_W-1];
	// C and V only mean something for the adder
	assign flags[1] = isArith & carry;
	assign flags[0] = isArith & overflow;

endmodule

// ==== src/controlUnit.sv ====
`timescale 1ns/100ps
`include "cpu_macros.svh"

module controlUnit
	import cpuPkg::*;
(
	input logic clk,
	input logic rst,
	input wordT ir,
	input logic skipTaken,
	output logic irLoad,
	output logic acLoad,
	output logic pcLoad,
	output flagsT flagLoad,
	output acSrcT acSrc,
	output operandSrcT operandSrc,
	output aluOpT aluOp,
	output pcSrcT pcSrc,
	output addrSrcT addrSrc,
	output flagSrcT flagSrc,
	output logic readMem,
	output logic writeMem
);

	cpuStateT state;
	opcodeT opcode;
	logic [3:0] subCode;
	logic [2:0] accOp;

	assign opcode = opcodeT'(ir[`CPU_WORD_W-1 -: `CPU_OPCODE_W]);
	assign subCode = ir[11:8];
	assign accOp = ir[7:5];

	// Fetch and execute simply alternate
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			state <= fetch;
		else if (state == fetch)
			state <= execute;
		else
			state <= fetch;
	end

	always_comb
	begin
		irLoad = 1'b0;
		acLoad = 1'b0;
		pcLoad = 1'b0;
		flagLoad = '0;
		acSrc = acAlu;
		operandSrc = operandMem;
		aluOp = aluAdd;
		pcSrc = pcStep1;
		addrSrc = addrPc;
		flagSrc = flagAlu;
		readMem = 1'b0;
		writeMem = 1'b0;

		if (state == fetch)
		begin
			addrSrc = addrPc;
			readMem = 1'b1;
			irLoad = 1'b1;
		end
		else
		begin
			// PC moves at the end of every execute cycle
			pcLoad = 1'b1;
			case (opcode)
				ldm:
				begin
					acSrc = acImm;
					acLoad = 1'b1;
				end
				lda:
				begin
					addrSrc = addrIr;
					readMem = 1'b1;
					acSrc = acMem;
					acLoad = 1'b1;
				end
				sta:
				begin
					addrSrc = addrIr;
					writeMem = 1'b1;
				end
				ana:
				begin
					addrSrc = addrIr;
					readMem = 1'b1;
					aluOp = aluAnd;
					acLoad = 1'b1;
					flagLoad = 4'b1100;
				end
				adm:
				begin
					operandSrc = operandImm;
					acLoad = 1'b1;
					flagLoad = 4'b1111;
				end
				ada:
				begin
					addrSrc = addrIr;
					readMem = 1'b1;
					acLoad = 1'b1;
					flagLoad = 4'b1111;
				end
				jma:
					pcSrc = pcJump;
				type2:
				begin
					case (subCode)
						// Accumulator group, selected by bits 7..5
						4'b0001:
						begin
							case (accOp)
								3'b010:
								begin
									acSrc = acZero;
									acLoad = 1'b1;
									flagSrc = flagClear;
									flagLoad = 4'b1100;
								end
								3'b011:
								begin
									aluOp = aluNot;
									acLoad = 1'b1;
									flagLoad = 4'b1100;
								end
								3'b100:
								begin
									aluOp = aluInc;
									acLoad = 1'b1;
								end
								default:
									acLoad = 1'b0;
							endcase
						end
						// SKP
						4'b1001:
						begin
							if (skipTaken)
								pcSrc = pcStep2;
						end
						// SET, mask in bits 7..4
						4'b0110:
						begin
							flagSrc = flagSet;
							flagLoad = ir[7:4];
						end
						default:
							pcSrc = pcStep1;
					endcase
				end
				default:
					pcSrc = pcStep1;
			endcase
		end
	end

endmodule

// ==== src/cpuPkg.sv ====
`include "cpu_macros.svh"

package cpuPkg;

	typedef logic [`CPU_WORD_W-1:0] wordT;

	// Z in bit 3, N in bit 2, C in bit 1, V in bit 0
	typedef logic [`CPU_FLAG_W-1:0] flagsT;

	typedef enum logic [`CPU_OPCODE_W-1:0]
	{
		ldm = 4'b0000,
		lda = 4'b0001,
		sta = 4'b0011,
		ana = 4'b0111,
		adm = 4'b1000,
		ada = 4'b1001,
		jma = 4'b1100,
		type2 = 4'b1111
	} opcodeT;

	typedef enum logic
	{
		fetch,
		execute
	} cpuStateT;

	typedef enum logic [1:0]
	{
		aluAdd,
		aluInc,
		aluAnd,
		aluNot
	} aluOpT;

	typedef enum logic [1:0]
	{
		acImm,
		acMem,
		acAlu,
		acZero
	} acSrcT;

	typedef enum logic
	{
		operandImm,
		operandMem
	} operandSrcT;

	typedef enum logic [1:0]
	{
		pcStep1,
		pcStep2,
		pcJump
	} pcSrcT;

	typedef enum logic
	{
		addrPc,
		addrIr
	} addrSrcT;

	// Clear pattern is Z=1, N=0
	typedef enum logic [1:0]
	{
		flagAlu,
		flagSet,
		flagClear
	} flagSrcT;

endpackage

// ==== src/cpuTop.sv ====
`timescale 1ns/100ps

module cpuTop
	import cpuPkg::*;
(
	input logic clk,
	input logic rst,
	input wordT memReadData,
	output wordT memAddr,
	output wordT memWriteData,
	output logic readMem,
	output logic writeMem
);

	wordT ir;
	logic skipTaken;
	logic irLoad;
	logic acLoad;
	logic pcLoad;
	flagsT flagLoad;
	acSrcT acSrc;
	operandSrcT operandSrc;
	aluOpT aluOp;
	pcSrcT pcSrc;
	addrSrcT addrSrc;
	flagSrcT flagSrc;

	controlUnit control_i
	(
		.clk(clk),
		.rst(rst),
		.ir(ir),
		.skipTaken(skipTaken),
		.irLoad(irLoad),
		.acLoad(acLoad),
		.pcLoad(pcLoad),
		.flagLoad(flagLoad),
		.acSrc(acSrc),
		.operandSrc(operandSrc),
		.aluOp(aluOp),
		.pcSrc(pcSrc),
		.addrSrc(addrSrc),
		.flagSrc(flagSrc),
		.readMem(readMem),
		.writeMem(writeMem)
	);

	datapath datapath_i
	(
		.clk(clk),
		.rst(rst),
		.irLoad(irLoad),
		.acLoad(acLoad),
		.pcLoad(pcLoad),
		.flagLoad(flagLoad),
		.acSrc(acSrc),
		.operandSrc(operandSrc),
		.aluOp(aluOp),
		.pcSrc(pcSrc),
		.addrSrc(addrSrc),
		.flagSrc(flagSrc),
		.memReadData(memReadData),
		.memAddr(memAddr),
		.memWriteData(memWriteData),
		.ir(ir),
		.skipTaken(skipTaken)
	);

endmodule

// ==== src/cpu_macros.svh ====
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// Data word and address width
`define CPU_WORD_W 16

// Major opcode field, IR bits 15..12
`define CPU_OPCODE_W 4

// Immediate and direct address field, IR bits 11..0
`define CPU_IMM_W 12

// Status flags Z N C V
`define CPU_FLAG_W 4

// First fetch address
`define CPU_RESET_PC 16'h0000

`endif

// ==== src/datapath.sv ====
`timescale 1ns/100ps
`include "cpu_macros.svh"

module datapath
	import cpuPkg::*;
(
	input logic clk,
	input logic rst,
	input logic irLoad,
	input logic acLoad,
	input logic pcLoad,
	input flagsT flagLoad,
	input acSrcT acSrc,
	input operandSrcT operandSrc,
	input aluOpT aluOp,
	input pcSrcT pcSrc,
	input addrSrcT addrSrc,
	input flagSrcT flagSrc,
	input wordT memReadData,
	output wordT memAddr,
	output wordT memWriteData,
	output wordT ir,
	output logic skipTaken
);

	wordT ac;
	wordT pc;
	flagsT sr;

	wordT immSigned;
	wordT immAddr;
	wordT operand;
	wordT aluResult;
	flagsT aluFlags;
	wordT acNext;
	wordT pcNext;
	flagsT flagSource;

	assign immSigned = {{(`CPU_WORD_W-`CPU_IMM_W){ir[`CPU_IMM_W-1]}}, ir[`CPU_IMM_W-1:0]};
	assign immAddr = {{(`CPU_WORD_W-`CPU_IMM_W){1'b0}}, ir[`CPU_IMM_W-1:0]};

	assign operand = (operandSrc == operandImm) ? immSigned : memReadData;

	arithLogicUnit alu_i
	(
		.a(ac),
		.b(operand),
		.aluOp(aluOp),
		.result(aluResult),
		.flags(aluFlags)
	);

	always_comb
	begin
		case (acSrc)
			acImm: acNext = immSigned;
			acMem: acNext = memReadData;
			acAlu: acNext = aluResult;
			default: acNext = '0;
		endcase
	end

	always_comb
	begin
		case (pcSrc)
			pcStep2: pcNext = pc + wordT'(2);
			pcJump: pcNext = immAddr;
			default: pcNext = pc + wordT'(1);
		endcase
	end

	always_comb
	begin
		case (flagSrc)
			flagSet: flagSource = ir[3:0];
			flagClear: flagSource = 4'b1000;
			default: flagSource = aluFlags;
		endcase
	end

	assign memAddr = (addrSrc == addrPc) ? pc : immAddr;
	assign memWriteData = ac;

	// Skip when any selected flag matches its expected value
	assign skipTaken = |(ir[7:4] & ~(sr ^ ir[3:0]));

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			ac <= '0;
			pc <= `CPU_RESET_PC;
			ir <= '0;
		end
		else
		begin
			if (acLoad)
				ac <= acNext;
			if (pcLoad)
				pc <= pcNext;
			if (irLoad)
				ir <= memReadData;
		end
	end

	// Per-bit masked flag update
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			sr <= '0;
		else
		begin
			for (int i = 0; i < `CPU_FLAG_W; i++)
			begin
				if (flagLoad[i])
					sr[i] <= flagSource[i];
			end
		end
	end

endmodule

// ==== vlog.f ====
+incdir+src
src/cpuPkg.sv
src/arithLogicUnit.sv
src/datapath.sv
src/controlUnit.sv
src/cpuTop.sv
sim/clockGen.sv
sim/cpuTb.sv
